// File: bench/tb_seven_seg_display.sv
`timescale 1ns/1ps

module tb_seven_seg_display;
    import seg_display_pkg::*;

    localparam int REFRESH_PERIOD  = 3;
    localparam int NUM_REQUESTS    = 60;
    localparam int SCAN_CYCLES     = DIGIT_COUNT * REFRESH_PERIOD;
    localparam int WATCHDOG_CYCLES = NUM_REQUESTS * (40 + 16 * REFRESH_PERIOD) + 200;
    localparam int ACK_LIMIT       = 100;

    typedef struct packed {
        logic [DIGIT_COUNT-1:0][DIGIT_WIDTH-1:0] digits;
        logic [DIGIT_COUNT-1:0]                  lit_mask;   // positions that light up
    } expect_t;

    logic         clk_tube = 1'b0;
    logic         rst_n;
    logic         display_req;
    display_req_t display_data;
    logic         display_ack;
    logic [6:0]   seg_tube;
    logic [7:0]   seg_enable;

    logic [15:0]  lfsr_state;
    string        test_name = "reset";
    int           fail_count = 0;
    expect_t      shown = '0;     // frame currently on the tubes
    expect_t      pending = '0;   // frame that takes over when ack rises
    int           scan_cycles = 0;
    logic         ack_prev = 1'b0;
    logic         req_at_edge;
    logic         rst_at_edge;

    seven_seg_display #(
        .REFRESH_PERIOD (REFRESH_PERIOD)
    ) UUT (
        .clk_tube     (clk_tube),
        .rst_n        (rst_n),
        .display_req  (display_req),
        .display_data (display_data),
        .display_ack  (display_ack),
        .seg_tube     (seg_tube),
        .seg_enable   (seg_enable)
    );

    always #50 clk_tube = ~clk_tube;

    // right shifting galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        lfsr_next = {1'b0, state[15:1]};
        if (state[0]) begin
            lfsr_next = lfsr_next ^ 16'hB400;
        end
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // returns active low g..a
    function automatic logic [6:0] segments_for_digit(input logic [3:0] digit);
        logic [6:0] on_segs;
        case (digit)
            4'd0:    on_segs = 7'h3F;
            4'd1:    on_segs = 7'h06;
            4'd2:    on_segs = 7'h5B;
            4'd3:    on_segs = 7'h4F;
            4'd4:    on_segs = 7'h66;
            4'd5:    on_segs = 7'h6D;
            4'd6:    on_segs = 7'h7D;
            4'd7:    on_segs = 7'h07;
            4'd8:    on_segs = 7'h7F;
            4'd9:    on_segs = 7'h6F;
            default: on_segs = 7'h00;
        endcase
        return ~on_segs;
    endfunction

    function automatic expect_t build_expect(input display_req_t req);
        expect_t     e;
        logic [31:0] rem;
        logic [31:0] mod_value;
        logic [31:0] place;
        e = '0;
        if (req.switch_mode) begin
            for (int p = 0; p < DIGIT_COUNT; p++) begin
                e.digits[p]   = {3'b000, req.value[p]};
                e.lit_mask[p] = req.show;   // no blanking in switch view
            end
        end else begin
            mod_value = req.value % 32'd100_000_000;
            rem       = mod_value;
            place     = 32'd1;
            for (int p = 0; p < DIGIT_COUNT; p++) begin
                e.digits[p]   = 4'(rem % 32'd10);
                // a position lights when the number reaches its place value
                e.lit_mask[p] = req.show && (p == 0 || mod_value >= place);
                rem           = rem / 32'd10;
                place         = place * 32'd10;
            end
        end
        return e;
    endfunction

    task automatic abort_run(input string reason);
        fail_count++;
        $display("%s", reason);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic value_mismatch(input string check, input logic [31:0] expected,
                                  input logic [31:0] actual);
        abort_run($sformatf("CHECK FAILED %s: %s expected %0h actual %0h",
                            test_name, check, expected, actual));
    endtask

    task automatic next_drive_point();
        @(posedge clk_tube);
        #10;
    endtask

    // checks the outputs every cycle, sampled well after the edge
    always begin : output_monitor
        logic [2:0] pos;
        logic [7:0] exp_enable;
        logic [6:0] exp_tube;
        @(posedge clk_tube);
        req_at_edge = display_req;
        rst_at_edge = rst_n;
        if (rst_n) begin
            scan_cycles++;
        end
        #40;
        if (!rst_at_edge) begin
            assert (display_ack == 1'b0)
                else value_mismatch("display_ack in reset", 32'd0, display_ack);
            assert (seg_enable == 8'hFF)
                else value_mismatch("seg_enable in reset", 32'hFF, seg_enable);
            assert (seg_tube == 7'h7F)
                else value_mismatch("seg_tube in reset", 32'h7F, seg_tube);
        end else begin
            // outputs lag the scan position by one cycle
            pos        = 3'(((scan_cycles - 1) / REFRESH_PERIOD) % DIGIT_COUNT);
            exp_enable = 8'hFF;
            exp_tube   = 7'h7F;
            if (shown.lit_mask[pos]) begin
                exp_enable[pos] = 1'b0;
                exp_tube        = segments_for_digit(shown.digits[pos]);
            end
            assert (seg_enable == exp_enable)
                else value_mismatch("seg_enable", exp_enable, seg_enable);
            assert (seg_tube == exp_tube)
                else value_mismatch("seg_tube", exp_tube, seg_tube);
            if (display_ack && !ack_prev) begin
                assert (req_at_edge)
                    else abort_run("display_ack rose while display_req was low");
                shown = pending;
            end
        end
        ack_prev = display_ack;
    end

    task automatic run_request(input display_req_t req);
        int latency;
        int release_cycles;
        int exp_latency;
        exp_latency = req.switch_mode ? 2 : 34;
        assert (!display_ack)
            else abort_run("display_ack still high before a new request");
        pending      = build_expect(req);
        display_data = req;
        display_req  = 1'b1;
        latency      = 0;
        while (!display_ack && latency < ACK_LIMIT) begin
            next_drive_point();
            latency++;
        end
        assert (display_ack)
            else abort_run($sformatf("no acknowledge within %0d cycles", ACK_LIMIT));
        assert (latency == exp_latency)
            else value_mismatch("ack latency", exp_latency, latency);
        display_req    = 1'b0;
        release_cycles = 0;
        while (display_ack && release_cycles < ACK_LIMIT) begin
            next_drive_point();
            release_cycles++;
        end
        assert (release_cycles == 1)
            else value_mismatch("ack release", 32'd1, release_cycles);
        repeat (SCAN_CYCLES) next_drive_point();   // one full scan of the new frame
    endtask

    initial begin
        display_req_t req;
        logic [31:0]  bits;
        lfsr_state   = 16'd44885;
        rst_n        = 1'b0;
        display_req  = 1'b0;
        display_data = '0;
        repeat (4) @(posedge clk_tube);
        #10;
        rst_n     = 1'b1;
        test_name = "after reset";
        repeat (SCAN_CYCLES) next_drive_point();
        for (int n = 0; n < NUM_REQUESTS; n++) begin
            if (n == 0) begin
                req.value       = 32'd0;   // zero shows a single 0
                req.switch_mode = 1'b0;
                req.show        = 1'b1;
            end else begin
                draw_bits(32, bits);
                req.value = bits;
                draw_bits(1, bits);
                req.switch_mode = bits[0];
                draw_bits(2, bits);
                req.show = bits[0] | bits[1];
                draw_bits(1, bits);
                if (bits[0]) begin
                    req.value = req.value & 32'h0000_0FFF;   // short numbers
                end
            end
            test_name = $sformatf("request %0d %s", n,
                                  req.switch_mode ? "switch" : "decimal");
            run_request(req);
        end
        if (fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_tube);
        abort_run($sformatf("watchdog expired after %0d cycles, the run did not finish",
                            WATCHDOG_CYCLES));
    end

endmodule

// File: rtl/bcd_converter.sv
`timescale 1ns/1ps

module bcd_converter (
    input  logic        clk_tube,
    input  logic        rst_n,
    input  logic        conv_start,
    input  logic [31:0] conv_value,
    output logic        conv_busy,
    output logic        conv_done,
    output logic [31:0] conv_digits
);
    import seg_display_pkg::*;

    localparam int BCD_DIGITS = 10;   // enough for 2^32 - 1
    localparam int BCD_WIDTH  = BCD_DIGITS * DIGIT_WIDTH;

    logic [VALUE_WIDTH-1:0] bin_q;
    logic [BCD_WIDTH-1:0]   bcd_q;
    logic [BCD_WIDTH-1:0]   bcd_adj;
    logic [4:0]             step_q;
    logic                   digits_valid;

    // add 3 to every digit of 5 or more before the shift
    always_comb begin
        for (int i = 0; i < BCD_DIGITS; i++) begin
            if (bcd_q[i*DIGIT_WIDTH +: DIGIT_WIDTH] >= DIGIT_WIDTH'(5)) begin
                bcd_adj[i*DIGIT_WIDTH +: DIGIT_WIDTH] =
                    bcd_q[i*DIGIT_WIDTH +: DIGIT_WIDTH] + DIGIT_WIDTH'(3);
            end else begin
                bcd_adj[i*DIGIT_WIDTH +: DIGIT_WIDTH] = bcd_q[i*DIGIT_WIDTH +: DIGIT_WIDTH];
            end
        end
    end

    always_ff @(posedge clk_tube) begin
        if (conv_start) begin
            bin_q <= conv_value;
            bcd_q <= '0;
        end else if (conv_busy) begin
            bcd_q <= {bcd_adj[BCD_WIDTH-2:0], bin_q[VALUE_WIDTH-1]};
            bin_q <= {bin_q[VALUE_WIDTH-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk_tube or negedge rst_n) begin
        if (!rst_n) begin
            conv_busy <= 1'b0;
            conv_done <= 1'b0;
            step_q    <= '0;
        end else begin
            conv_done <= 1'b0;
            if (conv_start) begin
                conv_busy <= 1'b1;
                step_q    <= '0;
            end else if (conv_busy) begin
                step_q <= step_q + 5'd1;
                if (step_q == 5'd31) begin   // last of 32 shifts
                    conv_busy <= 1'b0;
                    conv_done <= 1'b1;
                end
            end
        end
    end

    // upper two digits dropped, value modulo 10^8
    assign conv_digits = bcd_q[DIGIT_COUNT*DIGIT_WIDTH-1:0];

    always_comb begin
        digits_valid = 1'b1;
        for (int i = 0; i < DIGIT_COUNT; i++) begin
            if (conv_digits[i*DIGIT_WIDTH +: DIGIT_WIDTH] > DIGIT_WIDTH'(9)) begin
                digits_valid = 1'b0;
            end
        end
    end

    done_digits_decimal: assert property (@(posedge clk_tube) disable iff (!rst_n)
        conv_done |-> digits_valid);

    no_start_while_busy: assert property (@(posedge clk_tube) disable iff (!rst_n)
        conv_start |-> !conv_busy);

endmodule

// File: rtl/display_loader.sv
`timescale 1ns/1ps

module display_loader (
    input  logic                          clk_tube,
    input  logic                          rst_n,
    input  logic                          display_req,
    input  seg_display_pkg::display_req_t display_data,
    output logic                          display_ack,
    output logic                          conv_start,
    output logic [31:0]                   conv_value,
    input  logic                          conv_done,
    input  logic [31:0]                   conv_digits,
    output seg_display_pkg::digit_frame_t frame
);
    import seg_display_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_CONV,     // waiting for the converter
        S_ACK,      // switch view, build digits from the captured word
        S_WAIT      // ack high until req drops
    } state_t;

    state_t                                  state;
    display_word_u                           in_word;
    display_word_u                           word_q;
    logic                                    switch_q;
    logic                                    show_q;
    logic [DIGIT_COUNT-1:0][DIGIT_WIDTH-1:0] switch_digits;

    assign in_word.number = display_data.value;

    // converter is started in the sampling cycle so the decimal path keeps its latency
    assign conv_start  = (state == S_IDLE) && display_req && !display_data.switch_mode;
    assign conv_value  = in_word.number;
    assign display_ack = (state == S_WAIT);

    always_comb begin
        for (int i = 0; i < DIGIT_COUNT; i++) begin
            switch_digits[i] = DIGIT_WIDTH'(word_q.switch_view.switch_bits[i]);
        end
    end

    always_ff @(posedge clk_tube) begin
        if (state == S_IDLE && display_req) begin
            word_q   <= in_word;
            switch_q <= display_data.switch_mode;
            show_q   <= display_data.show;
        end
    end

    always_ff @(posedge clk_tube or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            frame <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (display_req) begin
                        state <= display_data.switch_mode ? S_ACK : S_CONV;
                    end
                end
                S_CONV: begin
                    if (conv_done) begin
                        frame.digits      <= conv_digits;
                        frame.switch_mode <= switch_q;
                        frame.show        <= show_q;
                        state             <= S_WAIT;
                    end
                end
                S_ACK: begin
                    frame.digits      <= switch_digits;
                    frame.switch_mode <= switch_q;
                    frame.show        <= show_q;
                    state             <= S_WAIT;
                end
                default: begin
                    if (!display_req) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // ack goes high on the edge after req was seen high
    ack_only_with_req: assert property (@(posedge clk_tube) disable iff (!rst_n)
        $rose(display_ack) |-> $past(display_req));

    done_only_converting: assert property (@(posedge clk_tube) disable iff (!rst_n)
        conv_done |-> state == S_CONV);

endmodule

// File: rtl/refresh_scanner.sv
`timescale 1ns/1ps

module refresh_scanner #(
    parameter int REFRESH_PERIOD = 100_000
) (
    input  logic       clk_tube,
    input  logic       rst_n,
    output logic [2:0] scan_pos
);

    localparam int TICK_WIDTH = (REFRESH_PERIOD > 1) ? $clog2(REFRESH_PERIOD) : 1;

    logic [TICK_WIDTH-1:0] tick_q;
    logic                  tick_wrap;

    assign tick_wrap = (tick_q == TICK_WIDTH'(REFRESH_PERIOD - 1));

    always_ff @(posedge clk_tube or negedge rst_n) begin
        if (!rst_n) begin
            tick_q   <= '0;
            scan_pos <= '0;
        end else if (tick_wrap) begin
            tick_q   <= '0;
            scan_pos <= scan_pos + 3'd1;   // wraps 7 to 0
        end else begin
            tick_q <= tick_q + TICK_WIDTH'(1);
        end
    end

    pos_moves_on_tick: assert property (@(posedge clk_tube) disable iff (!rst_n)
        !$stable(scan_pos) |-> $past(tick_wrap));

endmodule

// File: rtl/seg_display_pkg.sv
package seg_display_pkg;

    localparam int VALUE_WIDTH = 32;
    localparam int DIGIT_COUNT = 8;
    localparam int DIGIT_WIDTH = 4;

    // producer request, carried while display_req is high
    typedef struct packed {
        logic [VALUE_WIDTH-1:0] value;
        logic                   switch_mode;   // 1: one bit per digit
        logic                   show;          // 0: all digits dark
    } display_req_t;

    // captured value, read as a binary number or as switch bits
    typedef union packed {
        logic [VALUE_WIDTH-1:0] number;
        struct packed {
            logic [VALUE_WIDTH-DIGIT_COUNT-1:0] unused_bits;
            logic [DIGIT_COUNT-1:0]             switch_bits;   // bit p shown at position p
        } switch_view;
    } display_word_u;

    // what the driver scans out, digit 0 is the rightmost tube
    typedef struct packed {
        logic [DIGIT_COUNT-1:0][DIGIT_WIDTH-1:0] digits;
        logic                                    switch_mode;
        logic                                    show;
    } digit_frame_t;

endpackage

// File: rtl/seg_driver.sv
`timescale 1ns/1ps

module seg_driver (
    input  logic                          clk_tube,
    input  logic                          rst_n,
    input  seg_display_pkg::digit_frame_t frame,
    input  logic [2:0]                    scan_pos,
    output logic [6:0]                    seg_tube,
    output logic [7:0]                    seg_enable
);
    import seg_display_pkg::*;

    logic [2:0]             top_pos;
    logic [DIGIT_WIDTH-1:0] cur_digit;
    logic                   blanked;
    logic                   lit;
    logic [7:0]             enable_next;
    logic [6:0]             tube_next;

    // active low, bit order g..a
    function automatic logic [6:0] decode_digit(input logic [DIGIT_WIDTH-1:0] digit);
        case (digit)
            4'd0:    decode_digit = 7'b100_0000;
            4'd1:    decode_digit = 7'b111_1001;
            4'd2:    decode_digit = 7'b010_0100;
            4'd3:    decode_digit = 7'b011_0000;
            4'd4:    decode_digit = 7'b001_1001;
            4'd5:    decode_digit = 7'b001_0010;
            4'd6:    decode_digit = 7'b000_0010;
            4'd7:    decode_digit = 7'b111_1000;
            4'd8:    decode_digit = 7'b000_0000;
            4'd9:    decode_digit = 7'b001_0000;
            default: decode_digit = 7'b111_1111;
        endcase
    endfunction

    // highest nonzero digit, position 0 stays lit for a zero value
    always_comb begin
        top_pos = '0;
        for (int i = 1; i < DIGIT_COUNT; i++) begin
            if (frame.digits[i] != '0) begin
                top_pos = 3'(i);
            end
        end
    end

    assign cur_digit = frame.digits[scan_pos];
    assign blanked   = !frame.switch_mode && (scan_pos > top_pos);
    assign lit       = frame.show && !blanked;

    assign enable_next = lit ? ~(8'b0000_0001 << scan_pos) : 8'hFF;
    assign tube_next   = lit ? decode_digit(cur_digit) : 7'h7F;

    always_ff @(posedge clk_tube or negedge rst_n) begin
        if (!rst_n) begin
            seg_enable <= 8'hFF;   // all tubes off
            seg_tube   <= 7'h7F;
        end else begin
            seg_enable <= enable_next;
            seg_tube   <= tube_next;
        end
    end

    one_tube_at_most: assert property (@(posedge clk_tube) disable iff (!rst_n)
        $countones(~seg_enable) <= 1);

endmodule

// File: rtl/seven_seg_display.sv
`timescale 1ns/1ps

module seven_seg_display #(
    parameter int REFRESH_PERIOD = 100_000
) (
    input  logic                          clk_tube,
    input  logic                          rst_n,
    input  logic                          display_req,
    input  seg_display_pkg::display_req_t display_data,
    output logic                          display_ack,
    output logic [6:0]                    seg_tube,
    output logic [7:0]                    seg_enable
);
    import seg_display_pkg::*;

    logic                                 conv_start;
    logic [VALUE_WIDTH-1:0]               conv_value;
    logic                                 conv_done;
    logic [DIGIT_COUNT*DIGIT_WIDTH-1:0]   conv_digits;
    digit_frame_t                         frame;
    logic [2:0]                           scan_pos;

    display_loader u_loader (
        .clk_tube     (clk_tube),
        .rst_n        (rst_n),
        .display_req  (display_req),
        .display_data (display_data),
        .display_ack  (display_ack),
        .conv_start   (conv_start),
        .conv_value   (conv_value),
        .conv_done    (conv_done),
        .conv_digits  (conv_digits),
        .frame        (frame)
    );

    bcd_converter u_converter (
        .clk_tube    (clk_tube),
        .rst_n       (rst_n),
        .conv_start  (conv_start),
        .conv_value  (conv_value),
        .conv_busy   (),             // loader relies on conv_done only
        .conv_done   (conv_done),
        .conv_digits (conv_digits)
    );

    refresh_scanner #(
        .REFRESH_PERIOD (REFRESH_PERIOD)
    ) u_scanner (
        .clk_tube (clk_tube),
        .rst_n    (rst_n),
        .scan_pos (scan_pos)
    );

    seg_driver u_driver (
        .clk_tube   (clk_tube),
        .rst_n      (rst_n),
        .frame      (frame),
        .scan_pos   (scan_pos),
        .seg_tube   (seg_tube),
        .seg_enable (seg_enable)
    );

endmodule

// File: sources.f
rtl/seg_display_pkg.sv
rtl/display_loader.sv
rtl/bcd_converter.sv
rtl/refresh_scanner.sv
rtl/seg_driver.sv
rtl/seven_seg_display.sv
bench/tb_seven_seg_display.sv
